//--- cache_pkg.sv
// Geometry is fixed at 256 lines of 64 bytes; the backing store only covers the low 64 KiB
package cache_pkg;

    // CPU side
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int TAG_W    = 18;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 6;

    // Line geometry
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_W         = WORDS_PER_LINE * DATA_W;
    localparam int NUM_LINES      = 1 << INDEX_W;
    // Word select drops the two byte bits of the offset
    localparam int WORD_SEL_W     = OFFSET_W - 2;

    // Backing line memory
    localparam int MEM_LINE_ADDR_W = 10;
    localparam int MEM_LINES       = 1 << MEM_LINE_ADDR_W;
    localparam int MEM_LATENCY     = 4;
    localparam int LAT_CNT_W       = $clog2(MEM_LATENCY + 1);

    // Reset contents are byte address XOR this key
    localparam logic [DATA_W-1:0] MEM_INIT_KEY = 32'h5a5a0000;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;

endpackage

//--- ram_block.sv
// One entry per cache line; read is combinational, so the address must settle before use
`timescale 1ns/1ns

module ram_block #(
    parameter type entry_t = logic
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  cache_pkg::index_t addr_i,
    input  logic              we_i,
    input  entry_t            d_i,
    output entry_t            q_o
);
    import cache_pkg::*;

    entry_t mem [NUM_LINES];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[addr_i] <= d_i;
        end
    end

    assign q_o = mem[addr_i];

endmodule

//--- line_bus_if.sv
// Whole-line transfers only; one request at a time, no error or abort path
`timescale 1ns/1ns

interface line_bus_if;
    import cache_pkg::*;

    logic                       req;
    logic                       we;
    logic [MEM_LINE_ADDR_W-1:0] line_addr;
    line_t                      wdata;
    line_t                      rdata;
    // One-cycle pulse that ends a request
    logic                       ack;

    modport ctrl (
        output req,
        output we,
        output line_addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport mem (
        input  req,
        input  we,
        input  line_addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

//--- cpu_cache.sv
// Word-aligned accesses only, offset bits 1:0 are ignored; a line replace wins over a word write
`timescale 1ns/1ns

module cpu_cache (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               en_i,
    input  cache_pkg::index_t  index_i,
    input  cache_pkg::offset_t offset_i,
    input  logic               comp_i,
    input  logic               wr_i,
    input  cache_pkg::tag_t    tag_i,
    input  cache_pkg::word_t   data_i,
    input  logic               valid_i,
    input  logic               replace_line_i,
    input  cache_pkg::line_t   cl_i,
    output logic               hit_o,
    output logic               dirty_o,
    output cache_pkg::tag_t    tag_o,
    output cache_pkg::word_t   data_o,
    output logic               valid_o,
    output cache_pkg::line_t   cl_o
);
    import cache_pkg::*;

    logic [WORD_SEL_W-1:0]     word_sel;
    logic                      match;
    logic                      wr_allowed;
    logic                      wr_tag_valid;
    logic                      wr_dirty;
    logic                      dirty_d;
    logic                      dirty_q;
    logic                      valid_q;
    logic [WORDS_PER_LINE-1:0] word_we;
    word_t                     word_d [WORDS_PER_LINE];
    word_t                     word_q [WORDS_PER_LINE];

    assign word_sel = offset_i[OFFSET_W-1:2];
    assign match    = (tag_i == tag_o);

    // Compare writes land only on a tag match, plain writes always land
    assign wr_allowed = en_i & wr_i & (match | ~comp_i);

    assign wr_tag_valid = replace_line_i | (en_i & wr_i & ~comp_i);
    assign wr_dirty     = replace_line_i | wr_allowed;

    // Compare write marks the line dirty; a fresh fill is clean
    assign dirty_d = replace_line_i ? 1'b0 : comp_i;

    for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_word
        assign word_we[w] = replace_line_i | (wr_allowed & (word_sel == WORD_SEL_W'(w)));
        assign word_d[w]  = replace_line_i ? cl_i[w*DATA_W +: DATA_W] : data_i;
        // Word 0 sits in the low bits of the line
        assign cl_o[w*DATA_W +: DATA_W] = word_q[w];

        ram_block #(
            .entry_t (word_t)
        ) i_word_ram (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .addr_i   (index_i),
            .we_i     (word_we[w]),
            .d_i      (word_d[w]),
            .q_o      (word_q[w])
        );
    end

    ram_block #(
        .entry_t (tag_t)
    ) i_tag_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .addr_i   (index_i),
        .we_i     (wr_tag_valid),
        .d_i      (tag_i),
        .q_o      (tag_o)
    );

    ram_block #(
        .entry_t (logic)
    ) i_dirty_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .addr_i   (index_i),
        .we_i     (wr_dirty),
        .d_i      (dirty_d),
        .q_o      (dirty_q)
    );

    ram_block #(
        .entry_t (logic)
    ) i_valid_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .addr_i   (index_i),
        .we_i     (wr_tag_valid),
        .d_i      (valid_i),
        .q_o      (valid_q)
    );

    assign hit_o   = en_i & match;
    assign dirty_o = en_i & dirty_q;
    assign valid_o = en_i & valid_q;
    assign data_o  = word_q[word_sel];

endmodule

//--- cache_ctrl.sv
// One transfer at a time; the master must hold CYC, STB, WE, ADR and DAT until ACK even on a miss
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // Wishbone classic slave
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [cache_pkg::ADDR_W-1:0] wb_adr_i,
    input  cache_pkg::word_t             wb_dat_i,
    output cache_pkg::word_t             wb_dat_o,
    output logic                         wb_ack_o,
    // Cache array
    output logic                         en_o,
    output cache_pkg::index_t            index_o,
    output cache_pkg::offset_t           offset_o,
    output logic                         comp_o,
    output logic                         wr_o,
    output cache_pkg::tag_t              tag_o,
    output cache_pkg::word_t             data_o,
    output logic                         valid_o,
    output logic                         replace_line_o,
    output cache_pkg::line_t             cl_o,
    input  logic                         hit_i,
    input  logic                         dirty_i,
    input  cache_pkg::tag_t              tag_i,
    input  cache_pkg::word_t             data_i,
    input  logic                         valid_i,
    input  cache_pkg::line_t             cl_i,
    // Line memory
    line_bus_if.ctrl                     mem_bus
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEBACK,
        S_FILL,
        S_REPLACE,
        S_RESPOND
    } state_t;

    state_t                     state_q;
    state_t                     state_d;
    line_t                      fill_line_q;
    logic                       lookup_hit;
    logic [MEM_LINE_ADDR_W-1:0] victim_addr;
    logic [MEM_LINE_ADDR_W-1:0] fill_addr;

    // Address fields go straight to the array because the master holds them stable
    assign offset_o = wb_adr_i[OFFSET_W-1:0];
    assign index_o  = wb_adr_i[OFFSET_W +: INDEX_W];
    assign tag_o    = wb_adr_i[OFFSET_W+INDEX_W +: TAG_W];
    assign data_o   = wb_dat_i;

    assign lookup_hit = hit_i & valid_i;

    // Victim line address puts the low bits of the stored tag above the index
    assign victim_addr = {tag_i[MEM_LINE_ADDR_W-INDEX_W-1:0], index_o};
    assign fill_addr   = wb_adr_i[OFFSET_W +: MEM_LINE_ADDR_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (wb_cyc_i && wb_stb_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (lookup_hit) begin
                    state_d = S_RESPOND;
                end else if (valid_i && dirty_i) begin
                    state_d = S_WRITEBACK;
                end else begin
                    state_d = S_FILL;
                end
            end
            S_WRITEBACK: begin
                // req stays up and the memory takes the fill as a new request
                if (mem_bus.ack) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (mem_bus.ack) begin
                    state_d = S_REPLACE;
                end
            end
            S_REPLACE: state_d = S_RESPOND;
            S_RESPOND: state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // rdata is only valid in the ack cycle and is kept for the replace
    always_ff @(posedge clk_i) begin
        if (state_q == S_FILL && mem_bus.ack) begin
            fill_line_q <= mem_bus.rdata;
        end
    end

    // Array control
    assign en_o           = (state_q != S_IDLE);
    assign replace_line_o = (state_q == S_REPLACE);
    assign valid_o        = (state_q == S_REPLACE);
    assign cl_o           = fill_line_q;
    // The write is done in the ack cycle when the line is present even after a fill
    assign comp_o         = (state_q == S_RESPOND);
    assign wr_o           = (state_q == S_RESPOND) & wb_we_i;

    // Line bus
    assign mem_bus.req       = (state_q == S_WRITEBACK) || (state_q == S_FILL);
    assign mem_bus.we        = (state_q == S_WRITEBACK);
    assign mem_bus.line_addr = (state_q == S_WRITEBACK) ? victim_addr : fill_addr;
    assign mem_bus.wdata     = cl_i;

    // Wishbone response
    assign wb_ack_o = (state_q == S_RESPOND);
    assign wb_dat_o = data_i;

endmodule

//--- line_memory.sv
// Fixed latency, one request at a time; a request still high after ack starts the next one
`timescale 1ns/1ns

module line_memory (
    input  logic    clk_i,
    input  logic    arst_n_i,
    line_bus_if.mem bus
);
    import cache_pkg::*;

    line_t                mem [MEM_LINES];
    logic [LAT_CNT_W-1:0] lat_cnt_q;

    // Counts the cycles that req has been high
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lat_cnt_q <= '0;
        end else if (bus.ack) begin
            lat_cnt_q <= '0;
        end else if (bus.req) begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
        end else begin
            lat_cnt_q <= '0;
        end
    end

    assign bus.ack   = bus.req && (lat_cnt_q == LAT_CNT_W'(MEM_LATENCY));
    assign bus.rdata = mem[bus.line_addr];

    // Each word starts as its byte address XOR the key
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int l = 0; l < MEM_LINES; l++) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    mem[l][w*DATA_W +: DATA_W] <=
                        MEM_INIT_KEY ^ word_t'(l * (1 << OFFSET_W) + w * (DATA_W / 8));
                end
            end
        end else if (bus.ack && bus.we) begin
            mem[bus.line_addr] <= bus.wdata;
        end
    end

endmodule

//--- cache_top.sv
// Full-word Wishbone classic only, no SEL, ERR or bursts; addresses must stay below 64 KiB
`timescale 1ns/1ns

module cache_top (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [cache_pkg::ADDR_W-1:0] wb_adr_i,
    input  cache_pkg::word_t             wb_dat_i,
    output cache_pkg::word_t             wb_dat_o,
    output logic                         wb_ack_o
);
    import cache_pkg::*;

    // Controller to array
    logic    arr_en;
    index_t  arr_index;
    offset_t arr_offset;
    logic    arr_comp;
    logic    arr_wr;
    tag_t    arr_tag_d;
    word_t   arr_data_d;
    logic    arr_valid_d;
    logic    arr_replace;
    line_t   arr_line_d;
    // Array to controller
    logic    arr_hit;
    logic    arr_dirty;
    tag_t    arr_tag_q;
    word_t   arr_data_q;
    logic    arr_valid_q;
    line_t   arr_line_q;

    line_bus_if i_line_bus ();

    cache_ctrl i_cache_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .en_o           (arr_en),
        .index_o        (arr_index),
        .offset_o       (arr_offset),
        .comp_o         (arr_comp),
        .wr_o           (arr_wr),
        .tag_o          (arr_tag_d),
        .data_o         (arr_data_d),
        .valid_o        (arr_valid_d),
        .replace_line_o (arr_replace),
        .cl_o           (arr_line_d),
        .hit_i          (arr_hit),
        .dirty_i        (arr_dirty),
        .tag_i          (arr_tag_q),
        .data_i         (arr_data_q),
        .valid_i        (arr_valid_q),
        .cl_i           (arr_line_q),
        .mem_bus        (i_line_bus.ctrl)
    );

    cpu_cache i_cpu_cache (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_i           (arr_en),
        .index_i        (arr_index),
        .offset_i       (arr_offset),
        .comp_i         (arr_comp),
        .wr_i           (arr_wr),
        .tag_i          (arr_tag_d),
        .data_i         (arr_data_d),
        .valid_i        (arr_valid_d),
        .replace_line_i (arr_replace),
        .cl_i           (arr_line_d),
        .hit_o          (arr_hit),
        .dirty_o        (arr_dirty),
        .tag_o          (arr_tag_q),
        .data_o         (arr_data_q),
        .valid_o        (arr_valid_q),
        .cl_o           (arr_line_q)
    );

    line_memory i_line_memory (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (i_line_bus.mem)
    );

endmodule

//--- tb_cache_properties.sv
// Handshake assertions for cache_ctrl; idle during reset and assume one transfer at a time
`timescale 1ns/1ns

module tb_cache_properties (
    input logic clk_i,
    input logic arst_n_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic mem_req_i,
    input logic mem_ack_i
);
    int n_ack_strobe = 0;
    int n_ack_width  = 0;
    int n_req_hold   = 0;
    int fail_cnt;

    assign fail_cnt = n_ack_strobe + n_ack_width + n_req_hold;

    // ACK only inside an active bus cycle
    ack_needs_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
        n_ack_strobe++;
        $error("Wishbone ACK is high while CYC or STB is low");
    end

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_ack_i |=> !wb_ack_i)
    else begin
        n_ack_width++;
        $error("Wishbone ACK stayed high for more than one cycle");
    end

    // Line request must wait for its acknowledge
    req_until_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (mem_req_i && !mem_ack_i) |=> mem_req_i)
    else begin
        n_req_hold++;
        $error("Line bus request dropped before its acknowledge");
    end

endmodule

bind cache_ctrl tb_cache_properties i_ctrl_props (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_ack_i  (wb_ack_o),
    .mem_req_i (mem_bus.req),
    .mem_ack_i (mem_bus.ack)
);

//--- tb_cache_checker.sv
// Shadows only the low 64 KiB; transfers must be separated by at least one sample with STB low
`timescale 1ns/1ns

module tb_cache_checker (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [cache_pkg::ADDR_W-1:0] wb_adr_i,
    input  cache_pkg::word_t             wr_dat_i,
    input  cache_pkg::word_t             rd_dat_i,
    input  logic                         ack_i,
    input  logic [8*16-1:0]              test_name_i,
    input  int                           exp_lat_i,
    output int                           err_cnt_o,
    output int                           check_cnt_o
);
    import cache_pkg::*;

    word_t                                shadow [MEM_LINES * WORDS_PER_LINE];
    logic [MEM_LINE_ADDR_W+WORD_SEL_W-1:0] word_idx;
    logic                                 req;
    logic                                 req_prev;
    logic                                 active;
    int                                   lat;
    int                                   err_cnt = 0;
    int                                   check_cnt = 0;

    assign req      = wb_cyc_i & wb_stb_i;
    assign word_idx = wb_adr_i[MEM_LINE_ADDR_W+OFFSET_W-1:2];

    assign err_cnt_o   = err_cnt;
    assign check_cnt_o = check_cnt;

    // Sampled mid-cycle, where both the driven inputs and the DUT outputs are settled
    always @(negedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Every word starts as its byte address XOR the key
            for (int i = 0; i < MEM_LINES * WORDS_PER_LINE; i++) begin
                shadow[i] = MEM_INIT_KEY ^ word_t'(i * 4);
            end
            req_prev = 1'b0;
            active   = 1'b0;
            lat      = 0;
        end else begin
            if (req && !req_prev) begin
                active = 1'b1;
                lat    = 0;
            end
            if (active) begin
                lat = lat + 1;
            end
            if (ack_i) begin
                if (!active) begin
                    err_cnt++;
                    $display("ACK arrived while no transfer was in progress at %0t", $time);
                end else begin
                    if (exp_lat_i != 0) begin
                        check_cnt++;
                        if (lat != exp_lat_i) begin
                            err_cnt++;
                            $display("FAIL %0s latency: expected %0d, actual %0d",
                                     test_name_i, exp_lat_i, lat);
                        end
                    end
                    if (wb_we_i) begin
                        shadow[word_idx] = wr_dat_i;
                    end else begin
                        check_cnt++;
                        if (rd_dat_i !== shadow[word_idx]) begin
                            err_cnt++;
                            $display("FAIL %0s: expected %08h, actual %08h",
                                     test_name_i, shadow[word_idx], rd_dat_i);
                        end
                    end
                end
                active = 1'b0;
            end
            req_prev = req;
        end
    end

endmodule

//--- tb_cache.sv
// Full-word transfers below 64 KiB, one at a time, with STB low for a cycle between them
`timescale 1ns/1ns

module tb_cache;
    import cache_pkg::*;

    typedef struct {
        string             name;
        logic              we;
        logic [ADDR_W-1:0] adr;
        word_t             dat;
        int                lat;
    } stim_t;

    localparam int ACK_TIMEOUT = 64;
    // Cycles from STB sampled to ACK sampled
    localparam int LAT_HIT   = 2;
    localparam int LAT_CLEAN = MEM_LATENCY + 4;
    localparam int LAT_DIRTY = 2 * MEM_LATENCY + 5;

    logic              clk;
    logic              arst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    word_t             wb_wdat;
    word_t             wb_rdat;
    logic              wb_ack;
    logic [8*16-1:0]   cur_name;
    int                cur_lat;
    stim_t             tab [$];
    int                seed;
    int                chk_err;
    int                chk_cnt;
    int                timeout_cnt;
    int                prop_cnt;
    int                err_total;
    logic              rnd_we;
    logic [ADDR_W-1:0] rnd_adr;
    word_t             rnd_dat;

    cache_top i_cache_top (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdat),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack)
    );

    tb_cache_checker i_checker (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wr_dat_i    (wb_wdat),
        .rd_dat_i    (wb_rdat),
        .ack_i       (wb_ack),
        .test_name_i (cur_name),
        .exp_lat_i   (cur_lat),
        .err_cnt_o   (chk_err),
        .check_cnt_o (chk_cnt)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // Packs up to 16 characters for the checker port
    function automatic logic [8*16-1:0] name_bits(input string s);
        logic [8*16-1:0] v;
        v = '0;
        for (int i = 0; i < s.len() && i < 16; i++) begin
            v = {v[8*15-1:0], s[i]};
        end
        return v;
    endfunction

    task automatic add_stim(input string name, input logic we, input logic [ADDR_W-1:0] adr,
                            input word_t dat, input int lat);
        stim_t s;
        s.name = name;
        s.we   = we;
        s.adr  = adr;
        s.dat  = dat;
        s.lat  = lat;
        tab.push_back(s);
    endtask

    task automatic build_table();
        // Cold reads land in three untouched lines
        add_stim("cold_rd_0", 1'b0, 32'h0000_0000, '0, LAT_CLEAN);
        add_stim("cold_rd_1", 1'b0, 32'h0000_0104, '0, LAT_CLEAN);
        add_stim("cold_rd_2", 1'b0, 32'h0000_2a3c, '0, LAT_CLEAN);
        add_stim("hit_rd_0", 1'b0, 32'h0000_0108, '0, LAT_HIT);
        add_stim("hit_rd_1", 1'b0, 32'h0000_0000, '0, LAT_HIT);
        add_stim("wr_hit", 1'b1, 32'h0000_0110, 32'hcafe_0001, LAT_HIT);
        add_stim("rd_after_wr", 1'b0, 32'h0000_0110, '0, LAT_HIT);
        add_stim("rd_next_word", 1'b0, 32'h0000_0114, '0, LAT_HIT);
        add_stim("rd_prev_word", 1'b0, 32'h0000_010c, '0, LAT_HIT);
        // Same index 4, tag 1 pushes the dirty line out
        add_stim("evict_b", 1'b0, 32'h0000_4110, '0, LAT_DIRTY);
        add_stim("reread_a", 1'b0, 32'h0000_0110, '0, LAT_CLEAN);
        // Write miss allocates, then gets evicted in turn
        add_stim("wr_miss", 1'b1, 32'h0000_8004, 32'h1234_5678, LAT_CLEAN);
        add_stim("evict_wr_miss", 1'b0, 32'h0000_0000, '0, LAT_DIRTY);
        add_stim("rd_wr_miss", 1'b0, 32'h0000_8004, '0, LAT_CLEAN);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            add_stim($sformatf("wsel_wr_%0d", w), 1'b1, 32'h0000_0800 + 32'(w * 4),
                     32'h0bad_0000 + 32'(w * 32'h111), (w == 0) ? LAT_CLEAN : LAT_HIT);
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            add_stim($sformatf("wsel_rd_%0d", w), 1'b0, 32'h0000_0800 + 32'(w * 4), '0, LAT_HIT);
        end
    endtask

    // One classic cycle, held until ACK, dropped in the cycle after it
    task automatic wb_transfer(input string name, input logic we, input logic [ADDR_W-1:0] adr,
                               input word_t dat, input int lat);
        int   cycles;
        logic got;
        @(negedge clk);
        cur_name <= name_bits(name);
        cur_lat  <= lat;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdat  <= dat;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            got = wb_ack;
        end
        if (!got) begin
            timeout_cnt++;
            $display("Timeout: no ACK for %0s within %0d cycles", name, cycles);
        end
        @(negedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    initial begin
        seed        = 32'hc043;
        timeout_cnt = 0;
        arst_n      = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_wdat     = '0;
        cur_name    = '0;
        cur_lat     = 0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;

        foreach (tab[i]) begin
            if (timeout_cnt == 0) begin
                wb_transfer(tab[i].name, tab[i].we, tab[i].adr, tab[i].dat, tab[i].lat);
            end
        end

        // Random word accesses anywhere in the 64 KiB space
        for (int i = 0; i < 200 && timeout_cnt == 0; i++) begin
            rnd_we  = 1'($random(seed));
            rnd_adr = 32'($random(seed)) & 32'h0000_fffc;
            rnd_dat = 32'($random(seed));
            wb_transfer($sformatf("rnd_%0d", i), rnd_we, rnd_adr, rnd_dat, 0);
        end

        repeat (2) @(negedge clk);
        prop_cnt  = i_cache_top.i_cache_ctrl.i_ctrl_props.fail_cnt;
        err_total = chk_err + timeout_cnt + prop_cnt;
        $display("Errors: %0d in %0d checks (compare %0d, timeout %0d, assertion %0d)",
                 err_total, chk_cnt, chk_err, timeout_cnt, prop_cnt);
        if (err_total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
cache_pkg.sv
ram_block.sv
line_bus_if.sv
cpu_cache.sv
cache_ctrl.sv
line_memory.sv
cache_top.sv
tb_cache_properties.sv
tb_cache_checker.sv
tb_cache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds tb_cache with Verilator, runs it and decides pass or fail from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cache -f tb.f -o sim_cache > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_cache +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1
